// ==== Makefile ====
TOP := tb_udp_image_tx

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --top-module $(TOP) -f build.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "^=== PASS ===$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== build.f ====
udp_tx_pkg.sv
tx_sequencer.sv
pixel_fetch.sv
ip_header_csum.sv
frame_serializer.sv
udp_image_tx.sv
tb_udp_image_tx.sv

// ==== frame_serializer.sv ====
`timescale 1ns/1ps

module frame_serializer #(
    parameter int BEATS_PER_PKT = 8
) (
    input  logic                        eth_rxck,
    input  logic                        rst_rx,
    input  logic                        frame_load_i,
    input  udp_tx_pkg::conn_t           conn_i,
    input  udp_tx_pkg::mac_addr_t       my_mac_i,
    input  udp_tx_pkg::ip_addr_t        my_ip_i,
    input  udp_tx_pkg::csum_t           csum_i,
    input  logic [BEATS_PER_PKT*24-1:0] payload_i,
    output udp_tx_pkg::tx_stream_t      tx_o,
    output logic                        frame_sent_o
);
    import udp_tx_pkg::*;

    localparam int PAY_BYTES   = 3 * BEATS_PER_PKT;
    localparam int FRAME_BYTES = FRAME_HDR_BYTES + PAY_BYTES;
    localparam int FRAME_BITS  = FRAME_BYTES * 8;
    localparam int CNT_W       = $clog2(FRAME_BYTES + 1);

    localparam logic [15:0] IP_TOTAL_LEN = 16'(IP_HDR_BYTES + UDP_HDR_BYTES + PAY_BYTES);
    localparam logic [15:0] UDP_LEN      = 16'(UDP_HDR_BYTES + PAY_BYTES);

    logic [FRAME_BITS-1:0] frame_sr;
    logic [CNT_W-1:0]      bytes_left;
    logic                  sending;

    // byte out of the top of the shift register
    assign tx_o.data  = frame_sr[FRAME_BITS-1 -: 8];
    assign tx_o.valid = sending;
    assign tx_o.last  = sending && (bytes_left == CNT_W'(1));

    ////////////////////////////////////////////////////////////
    // frame image, first byte at the top
    ////////////////////////////////////////////////////////////
    always_ff @(posedge eth_rxck) begin
        if (frame_load_i) begin
            frame_sr <= {
                // ethernet
                conn_i.dst_mac, my_mac_i, ETH_TYPE_IPV4,
                // ipv4
                IP_VER_IHL, IP_TOS, IP_TOTAL_LEN,
                IP_IDENT, IP_FLAGS_DF, IP_TTL, IP_PROTO_UDP, csum_i,
                my_ip_i, conn_i.dst_ip,
                // udp, checksum left at zero
                conn_i.src_port, conn_i.dst_port, UDP_LEN, 16'h0000,
                payload_i
            };
        end else if (sending) begin
            frame_sr <= {frame_sr[FRAME_BITS-9:0], 8'h00};
        end
    end

    // byte counter and end-of-frame pulse
    always_ff @(posedge eth_rxck) begin
        if (rst_rx) begin
            sending      <= 1'b0;
            bytes_left   <= '0;
            frame_sent_o <= 1'b0;
        end else begin
            frame_sent_o <= tx_o.last;
            if (frame_load_i) begin
                sending    <= 1'b1;
                bytes_left <= CNT_W'(FRAME_BYTES);
            end else if (sending) begin
                bytes_left <= bytes_left - CNT_W'(1);
                if (bytes_left == CNT_W'(1)) begin
                    sending <= 1'b0;
                end
            end
        end
    end

endmodule

// ==== ip_header_csum.sv ====
`timescale 1ns/1ps

module ip_header_csum (
    input  logic                 eth_rxck,
    input  logic                 rst_rx,
    input  logic                 csum_start_i,
    input  udp_tx_pkg::conn_t    conn_i,
    input  udp_tx_pkg::ip_addr_t my_ip_i,
    input  logic [15:0]          ip_total_len_i,
    output udp_tx_pkg::csum_t    csum_o,
    output logic                 csum_valid_o
);
    import udp_tx_pkg::*;

    csum_t       hdr_w [10];
    // bit 16 holds the carry still to be added back
    logic [16:0] acc;
    logic [3:0]  cnt;
    logic        busy;

    // the ten ipv4 header words, checksum field as zero
    always_comb begin
        hdr_w[0] = {IP_VER_IHL, IP_TOS};
        hdr_w[1] = ip_total_len_i;
        hdr_w[2] = IP_IDENT;
        hdr_w[3] = IP_FLAGS_DF;
        hdr_w[4] = {IP_TTL, IP_PROTO_UDP};
        hdr_w[5] = 16'h0000;
        hdr_w[6] = my_ip_i[31:16];
        hdr_w[7] = my_ip_i[15:0];
        hdr_w[8] = conn_i.dst_ip[31:16];
        hdr_w[9] = conn_i.dst_ip[15:0];
    end

    // control, word 0 on start then one word per cycle
    always_ff @(posedge eth_rxck) begin
        if (rst_rx) begin
            busy         <= 1'b0;
            cnt          <= '0;
            csum_valid_o <= 1'b0;
        end else begin
            csum_valid_o <= busy && (cnt == 4'd10);
            if (csum_start_i) begin
                busy <= 1'b1;
                cnt  <= 4'd1;
            end else if (busy) begin
                cnt <= cnt + 4'd1;
                if (cnt == 4'd10) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    // end-around carry folded in on the following add
    always_ff @(posedge eth_rxck) begin
        if (csum_start_i) begin
            acc <= {1'b0, hdr_w[0]};
        end else if (busy && cnt < 4'd10) begin
            acc <= {1'b0, acc[15:0]} + {16'd0, acc[16]} + {1'b0, hdr_w[cnt]};
        end else if (busy) begin
            // final fold and invert
            csum_o <= ~(acc[15:0] + {15'd0, acc[16]});
        end
    end

endmodule

// ==== pixel_fetch.sv ====
`timescale 1ns/1ps

module pixel_fetch #(
    parameter int BEATS_PER_PKT = 8
) (
    input  logic                        eth_rxck,
    input  logic                        rst_rx,
    input  logic                        fetch_start_i,
    input  udp_tx_pkg::pkt_cnt_t        pkt_idx_i,
    output udp_tx_pkg::axi_ar_t         ar_o,
    input  logic                        arready_i,
    input  udp_tx_pkg::axi_r_t          r_i,
    output logic                        rready_o,
    output logic                        fetch_done_o,
    output logic [BEATS_PER_PKT*24-1:0] payload_o
);
    import udp_tx_pkg::*;

    localparam int          PAY_BITS    = BEATS_PER_PKT * 24;
    // bytes per burst, four per word
    localparam logic [31:0] BURST_BYTES = 32'(BEATS_PER_PKT * 4);
    localparam logic [7:0]  AR_LEN      = 8'(BEATS_PER_PKT - 1);

    logic [31:0] ar_addr;
    logic        ar_valid;
    logic        busy;
    logic        beat;

    assign ar_o.addr  = ar_addr;
    assign ar_o.len   = AR_LEN;
    assign ar_o.valid = ar_valid;

    // data accepted whenever a burst is open
    assign rready_o = busy;
    assign beat     = r_i.valid && busy;

    ////////////////////////////////////////////////////////////
    // address phase
    ////////////////////////////////////////////////////////////
    always_ff @(posedge eth_rxck) begin
        if (rst_rx) begin
            ar_valid <= 1'b0;
        end else if (fetch_start_i) begin
            ar_valid <= 1'b1;
        end else if (arready_i) begin
            ar_valid <= 1'b0;
        end
    end

    // address held steady until taken
    always_ff @(posedge eth_rxck) begin
        if (fetch_start_i) begin
            ar_addr <= {24'd0, pkt_idx_i} * BURST_BYTES;
        end
    end

    ////////////////////////////////////////////////////////////
    // data phase
    ////////////////////////////////////////////////////////////
    always_ff @(posedge eth_rxck) begin
        if (rst_rx) begin
            busy         <= 1'b0;
            fetch_done_o <= 1'b0;
        end else begin
            fetch_done_o <= beat && r_i.last;
            if (fetch_start_i) begin
                busy <= 1'b1;
            end else if (beat && r_i.last) begin
                busy <= 1'b0;
            end
        end
    end

    // shift in red, green, blue per beat
    // first beat ends up in the top bytes
    // alpha byte 31:24 dropped
    always_ff @(posedge eth_rxck) begin
        if (beat) begin
            payload_o <= {payload_o[PAY_BITS-25:0],
                          r_i.data[7:0], r_i.data[15:8], r_i.data[23:16]};
        end
    end

endmodule

// ==== tb_input.dat ====
// conn words: mac hi, mac lo, own ip, dst mac hi, dst mac lo, dst ip, {src port, dst port}
// then 5 switch codes, then 64 pixel words {alpha, blue, green, red}
000002AB CDEF0001 C0A80A02 00000011 22334455 C0A80A01 04D2162E
000002AB CDEF0002 0A000005 00006677 8899AABB 0A000001 1F902328
00000000 00000002 00000003 00000004 00000007
FF804000 FE814101 FD824202 FC834303 FB844404 FA854505 F9864606 F8874707
F7884808 F6894909 F58A4A0A F48B4B0B F38C4C0C F28D4D0D F18E4E0E F08F4F0F
EF905010 EE915111 ED925212 EC935313 EB945414 EA955515 E9965616 E8975717
E7985818 E6995919 E59A5A1A E49B5B1B E39C5C1C E29D5D1D E19E5E1E E09F5F1F
DFA06020 DEA16121 DDA26222 DCA36323 DBA46424 DAA56525 D9A66626 D8A76727
D7A86828 D6A96929 D5AA6A2A D4AB6B2B D3AC6C2C D2AD6D2D D1AE6E2E D0AF6F2F
CFB07030 CEB17131 CDB27232 CCB37333 CBB47434 CAB57535 C9B67636 C8B77737
C7B87838 C6B97939 C5BA7A3A C4BB7B3B C3BC7C3C C2BD7D3D C1BE7E3E C0BF7F3F

// ==== tb_udp_image_tx.sv ====
`timescale 1ns/1ps

module tb_udp_image_tx;
    import udp_tx_pkg::*;

    localparam int BEATS    = 8;
    localparam int PAY      = 3 * BEATS;
    localparam int FLEN     = FRAME_HDR_BYTES + PAY;
    localparam int N_RUNS   = 5;
    // word 0..6 conn A, 7..13 conn B, 14..18 switch codes, then 64 pixels
    localparam int CODE_BASE = 14;
    localparam int PIX_BASE  = 19;

    logic       eth_rxck;
    logic       rst_rx;
    logic       start_i;
    conn_t      conn_i;
    mac_addr_t  my_mac_i;
    ip_addr_t   my_ip_i;
    logic [3:0] pkt_sel_i;
    axi_ar_t    ar_o;
    logic       arready_i;
    axi_r_t     r_i;
    logic       rready_o;
    tx_stream_t tx_o;
    logic       done_o;

    logic [31:0] in_words [0:PIX_BASE+63];
    logic [7:0]  exp_frame [FLEN];
    int          wr_pos;
    int          errors;
    int          bursts_done;
    int          run_bursts_base;
    int          frames_seen;
    int          done_seen;
    logic        prev_valid;
    realtime     wd_limit = 0.0;

    udp_image_tx #(.BEATS_PER_PKT(BEATS)) dut (
        .eth_rxck  (eth_rxck),
        .rst_rx    (rst_rx),
        .start_i   (start_i),
        .conn_i    (conn_i),
        .my_mac_i  (my_mac_i),
        .my_ip_i   (my_ip_i),
        .pkt_sel_i (pkt_sel_i),
        .ar_o      (ar_o),
        .arready_i (arready_i),
        .r_i       (r_i),
        .rready_o  (rready_o),
        .tx_o      (tx_o),
        .done_o    (done_o)
    );

    // 125 MHz
    initial begin
        eth_rxck = 1'b0;
        forever #4 eth_rxck = ~eth_rxck;
    end

    // next edge, then settle
    task automatic step();
        @(posedge eth_rxck);
        #1;
    endtask

    // packets per run for a switch code
    function automatic int expected_pkts(input logic [3:0] code);
        if (code <= 4'd1) begin
            return 1;
        end
        if (code <= 4'd4) begin
            return 1 << (code - 4'd1);
        end
        return 8;
    endfunction

    // append a field msb first
    task automatic put_bytes(input logic [63:0] val, input int nbytes);
        int j;
        for (j = nbytes - 1; j >= 0; j--) begin
            exp_frame[wr_pos] = val[j*8 +: 8];
            wr_pos++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // expected frame image
    ////////////////////////////////////////////////////////////
    task automatic build_frame(input conn_t c, input mac_addr_t mac, input ip_addr_t ip,
                               input int k);
        int          b;
        logic [31:0] w;
        logic [31:0] sum;
        wr_pos = 0;
        put_bytes(64'(c.dst_mac), 6);
        put_bytes(64'(mac), 6);
        put_bytes(64'(ETH_TYPE_IPV4), 2);
        put_bytes(64'({IP_VER_IHL, IP_TOS}), 2);
        put_bytes(64'(IP_HDR_BYTES + UDP_HDR_BYTES + PAY), 2);
        put_bytes(64'({IP_IDENT, IP_FLAGS_DF, IP_TTL, IP_PROTO_UDP}), 6);
        // checksum slot held at zero while summing
        put_bytes(64'd0, 2);
        put_bytes(64'({ip, c.dst_ip}), 8);
        put_bytes(64'({c.src_port, c.dst_port}), 4);
        put_bytes(64'(UDP_HDR_BYTES + PAY), 2);
        put_bytes(64'd0, 2);
        // red, green and blue of each word
        // alpha byte dropped
        for (b = 0; b < BEATS; b++) begin
            w = in_words[PIX_BASE + (k * BEATS + b) % 64];
            put_bytes(64'(w[7:0]), 1);
            put_bytes(64'(w[15:8]), 1);
            put_bytes(64'(w[23:16]), 1);
        end
        sum = 32'd0;
        for (b = ETH_HDR_BYTES; b < ETH_HDR_BYTES + IP_HDR_BYTES; b += 2) begin
            sum = sum + {16'd0, exp_frame[b], exp_frame[b + 1]};
        end
        // fold carries back until none remain
        while (sum[31:16] != 16'd0) begin
            sum = {16'd0, sum[15:0]} + {16'd0, sum[31:16]};
        end
        exp_frame[24] = ~sum[15:8];
        exp_frame[25] = ~sum[7:0];
    endtask

    ////////////////////////////////////////////////////////////
    // AXI read slave with random stalls
    ////////////////////////////////////////////////////////////
    initial begin : mem_model
        int          base;
        int          len;
        int          b;
        logic [31:0] req_addr;
        logic [31:0] exp_addr;
        bursts_done = 0;
        void'($urandom(32'h6031));
        forever begin
            step();
            if (ar_o.valid) begin
                req_addr = ar_o.addr;
                repeat ($urandom_range(3, 0)) step();
                assert (ar_o.valid && ar_o.addr == req_addr) else begin
                    $display("read address changed or dropped before it was accepted");
                    errors++;
                end
                // burst k of a run starts at word k times BEATS
                exp_addr = 32'((bursts_done - run_bursts_base) * BEATS * 4);
                assert (ar_o.addr == exp_addr) else begin
                    $display("Error: ar_o.addr got 0x%h expected 0x%h", ar_o.addr, exp_addr);
                    errors++;
                end
                assert (ar_o.len == 8'(BEATS - 1)) else begin
                    $display("Error: ar_o.len got 0x%h expected 0x%h",
                             ar_o.len, 8'(BEATS - 1));
                    errors++;
                end
                arready_i = 1'b1;
                base      = int'(ar_o.addr >> 2);
                len       = int'(ar_o.len);
                step();
                arready_i = 1'b0;
                for (b = 0; b <= len; b++) begin
                    r_i.valid = 1'b0;
                    // gap in r valid
                    repeat ($urandom_range(2, 0)) step();
                    assert (rready_o) else begin
                        $display("rready_o low while a burst is still open");
                        errors++;
                    end
                    r_i.data  = in_words[PIX_BASE + (base + b) % 64];
                    r_i.last  = (b == len);
                    r_i.valid = 1'b1;
                    step();
                end
                r_i = '0;
                bursts_done++;
            end
        end
    end

    // frame starts and done pulses
    initial begin : stream_monitor
        frames_seen = 0;
        done_seen   = 0;
        prev_valid  = 1'b0;
        forever begin
            step();
            if (tx_o.valid && !prev_valid) begin
                frames_seen++;
            end
            if (done_o) begin
                done_seen++;
            end
            prev_valid = tx_o.valid;
        end
    end

    // compare one frame against exp_frame byte by byte
    task automatic check_frame(input int k, input int npk, input int bursts_at_start);
        int i;
        while (!tx_o.valid) begin
            step();
        end
        assert (bursts_done - bursts_at_start >= k + 1) else begin
            $display("frame %0d started before its payload burst was complete", k);
            errors++;
        end
        for (i = 0; i < FLEN; i++) begin
            assert (tx_o.valid) else begin
                $display("tx_o.valid dropped at byte %0d of frame %0d", i, k);
                errors++;
            end
            assert (tx_o.data == exp_frame[i]) else begin
                $display("Error: tx_o.data frame %0d byte %0d got 0x%h expected 0x%h",
                         k, i, tx_o.data, exp_frame[i]);
                errors++;
            end
            assert (tx_o.last == (i == FLEN - 1)) else begin
                $display("Error: tx_o.last frame %0d byte %0d got 0x%h expected 0x%h",
                         k, i, tx_o.last, (i == FLEN - 1));
                errors++;
            end
            step();
        end
        assert (!tx_o.valid) else begin
            $display("tx_o.valid still high after %0d bytes of frame %0d", FLEN, k);
            errors++;
        end
        assert (done_o == (k == npk - 1)) else begin
            $display("Error: done_o after frame %0d got 0x%h expected 0x%h",
                     k, done_o, (k == npk - 1));
            errors++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // one run of packets for one switch code
    ////////////////////////////////////////////////////////////
    task automatic run_packets(input int run, input int conn_base);
        conn_t      c;
        mac_addr_t  mac;
        ip_addr_t   ip;
        logic [3:0] code;
        int         npk;
        int         k;
        int         err_before;
        int         frames_before;
        int         done_before;
        int         bursts_before;
        mac        = {in_words[conn_base][15:0], in_words[conn_base + 1]};
        ip         = in_words[conn_base + 2];
        c.dst_mac  = {in_words[conn_base + 3][15:0], in_words[conn_base + 4]};
        c.dst_ip   = in_words[conn_base + 5];
        c.src_port = in_words[conn_base + 6][31:16];
        c.dst_port = in_words[conn_base + 6][15:0];
        code       = in_words[CODE_BASE + run][3:0];
        npk        = expected_pkts(code);
        err_before    = errors;
        frames_before = frames_seen;
        done_before   = done_seen;
        bursts_before = bursts_done;
        run_bursts_base = bursts_done;
        conn_i    = c;
        my_mac_i  = mac;
        my_ip_i   = ip;
        pkt_sel_i = code;
        start_i   = 1'b1;
        step();
        start_i = 1'b0;
        for (k = 0; k < npk; k++) begin
            build_frame(c, mac, ip, k);
            check_frame(k, npk, bursts_before);
        end
        // quiet tail catches stray frames or pulses
        repeat (20) step();
        assert (frames_seen - frames_before == npk) else begin
            $display("%0d frames sent where %0d were expected",
                     frames_seen - frames_before, npk);
            errors++;
        end
        assert (done_seen - done_before == 1) else begin
            $display("done_o pulsed %0d times in one run", done_seen - done_before);
            errors++;
        end
        $display("test %0d: switch code %0d, %0d frames: %s", run + 2, code, npk,
                 (errors == err_before) ? "ok" : "errors");
    endtask

    initial begin : main
        int i;
        int total_pkts;
        int err_before;
        rst_rx    = 1'b1;
        start_i   = 1'b0;
        conn_i    = '0;
        my_mac_i  = '0;
        my_ip_i   = '0;
        pkt_sel_i = 4'd0;
        arready_i = 1'b0;
        r_i       = '0;
        errors    = 0;
        run_bursts_base = 0;
        $readmemh("tb_input.dat", in_words);
        total_pkts = 0;
        for (i = 0; i < N_RUNS; i++) begin
            total_pkts += expected_pkts(in_words[CODE_BASE + i][3:0]);
        end
        // frame plus burst plus slack per packet in ns
        wd_limit = total_pkts * (FLEN + 64 + 40) * 8.0;
        repeat (10) @(posedge eth_rxck);
        #1;
        rst_rx = 1'b0;

        // idle outputs with no start
        err_before = errors;
        for (i = 0; i < 20; i++) begin
            assert (!tx_o.valid && !done_o && !ar_o.valid && !rready_o) else begin
                $display("outputs active after reset with no start pulse");
                errors++;
            end
            step();
        end
        $display("test 1: idle after reset: %s", (errors == err_before) ? "ok" : "errors");

        // last run switches to conn B
        for (i = 0; i < N_RUNS; i++) begin
            run_packets(i, (i == N_RUNS - 1) ? 7 : 0);
        end

        $display("tests: %0d, errors: %0d", N_RUNS + 1, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin : watchdog
        wait (wd_limit > 0.0);
        #(wd_limit);
        $display("watchdog expired at %0.1f ns before all runs finished", $realtime);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

// ==== tx_sequencer.sv ====
`timescale 1ns/1ps

module tx_sequencer (
    input  logic                  eth_rxck,
    input  logic                  rst_rx,
    input  logic                  start_i,
    input  logic [3:0]            pkt_sel_i,
    input  udp_tx_pkg::conn_t     conn_i,
    input  udp_tx_pkg::mac_addr_t my_mac_i,
    input  udp_tx_pkg::ip_addr_t  my_ip_i,
    input  logic                  fetch_done_i,
    input  logic                  csum_valid_i,
    input  logic                  frame_sent_i,
    output logic                  fetch_start_o,
    output udp_tx_pkg::pkt_cnt_t  pkt_idx_o,
    output logic                  csum_start_o,
    output logic                  frame_load_o,
    output udp_tx_pkg::conn_t     conn_o,
    output udp_tx_pkg::mac_addr_t my_mac_o,
    output udp_tx_pkg::ip_addr_t  my_ip_o,
    output logic                  done_o
);
    import udp_tx_pkg::*;

    tx_state_e state;
    pkt_cnt_t  pkt_total;
    pkt_cnt_t  sent_cnt;
    logic      fetch_ready;
    logic      last_pkt;
    logic      more_pkts;

    // frame in flight is the last one of the run
    assign last_pkt  = (sent_cnt == pkt_total - 8'd1);
    // another burst still to fetch
    assign more_pkts = (pkt_idx_o != pkt_total - 8'd1);
    // frame_sent lands one cycle after the final byte
    assign done_o    = (state == SEND) && frame_sent_i && last_pkt;

    // run settings, taken on start only
    always_ff @(posedge eth_rxck) begin
        if (start_i && state == IDLE) begin
            conn_o   <= conn_i;
            my_mac_o <= my_mac_i;
            my_ip_o  <= my_ip_i;
        end
    end

    ////////////////////////////////////////////////////////////
    // packet run FSM
    ////////////////////////////////////////////////////////////
    always_ff @(posedge eth_rxck) begin
        if (rst_rx) begin
            state         <= IDLE;
            pkt_total     <= '0;
            sent_cnt      <= '0;
            pkt_idx_o     <= '0;
            fetch_ready   <= 1'b0;
            fetch_start_o <= 1'b0;
            csum_start_o  <= 1'b0;
            frame_load_o  <= 1'b0;
        end else begin
            // single cycle pulses by default
            fetch_start_o <= 1'b0;
            csum_start_o  <= 1'b0;
            frame_load_o  <= 1'b0;
            // remember a burst that finished during SEND
            if (fetch_done_i) begin
                fetch_ready <= 1'b1;
            end
            case (state)
                IDLE: begin
                    if (start_i) begin
                        pkt_total     <= pkt_count_f(pkt_sel_i);
                        sent_cnt      <= '0;
                        pkt_idx_o     <= '0;
                        fetch_start_o <= 1'b1;
                        fetch_ready   <= 1'b0;
                        state         <= FETCH;
                    end
                end
                FETCH: begin
                    if (fetch_done_i) begin
                        csum_start_o <= 1'b1;
                        state        <= CSUM;
                    end
                end
                CSUM: begin
                    if (csum_valid_i) begin
                        frame_load_o <= 1'b1;
                        state        <= SEND;
                        // overlap next burst with this frame
                        if (more_pkts) begin
                            fetch_start_o <= 1'b1;
                            fetch_ready   <= 1'b0;
                            pkt_idx_o     <= pkt_idx_o + 8'd1;
                        end
                    end
                end
                SEND: begin
                    if (frame_sent_i) begin
                        sent_cnt <= sent_cnt + 8'd1;
                        if (last_pkt) begin
                            state <= DONE;
                        end else if (fetch_ready) begin
                            csum_start_o <= 1'b1;
                            state        <= CSUM;
                        end else begin
                            state <= WAIT_FETCH;
                        end
                    end
                end
                WAIT_FETCH: begin
                    // memory side still stretching the burst
                    if (fetch_ready) begin
                        csum_start_o <= 1'b1;
                        state        <= CSUM;
                    end
                end
                DONE: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

// ==== udp_image_tx.sv ====
`timescale 1ns/1ps

module udp_image_tx #(
    parameter int BEATS_PER_PKT = 8
) (
    input  logic                  eth_rxck,
    input  logic                  rst_rx,
    input  logic                  start_i,
    input  udp_tx_pkg::conn_t     conn_i,
    input  udp_tx_pkg::mac_addr_t my_mac_i,
    input  udp_tx_pkg::ip_addr_t  my_ip_i,
    input  logic [3:0]            pkt_sel_i,
    output udp_tx_pkg::axi_ar_t   ar_o,
    input  logic                  arready_i,
    input  udp_tx_pkg::axi_r_t    r_i,
    output logic                  rready_o,
    output udp_tx_pkg::tx_stream_t tx_o,
    output logic                  done_o
);
    import udp_tx_pkg::*;

    // ip total length, header words plus payload
    localparam logic [15:0] IP_TOTAL_LEN =
        16'(IP_HDR_BYTES + UDP_HDR_BYTES + 3 * BEATS_PER_PKT);

    // sequencer handshakes
    logic      fetch_start;
    logic      fetch_done;
    pkt_cnt_t  pkt_idx;
    logic      csum_start;
    logic      csum_valid;
    csum_t     ip_csum;
    logic      frame_load;
    logic      frame_sent;
    logic [BEATS_PER_PKT*24-1:0] payload;

    // settings held for the whole run
    conn_t     conn_q;
    mac_addr_t my_mac_q;
    ip_addr_t  my_ip_q;

    tx_sequencer u_seq (
        .eth_rxck       (eth_rxck),
        .rst_rx         (rst_rx),
        .start_i        (start_i),
        .pkt_sel_i      (pkt_sel_i),
        .conn_i         (conn_i),
        .my_mac_i       (my_mac_i),
        .my_ip_i        (my_ip_i),
        .fetch_done_i   (fetch_done),
        .csum_valid_i   (csum_valid),
        .frame_sent_i   (frame_sent),
        .fetch_start_o  (fetch_start),
        .pkt_idx_o      (pkt_idx),
        .csum_start_o   (csum_start),
        .frame_load_o   (frame_load),
        .conn_o         (conn_q),
        .my_mac_o       (my_mac_q),
        .my_ip_o        (my_ip_q),
        .done_o         (done_o)
    );

    pixel_fetch #(.BEATS_PER_PKT(BEATS_PER_PKT)) u_fetch (
        .eth_rxck       (eth_rxck),
        .rst_rx         (rst_rx),
        .fetch_start_i  (fetch_start),
        .pkt_idx_i      (pkt_idx),
        .ar_o           (ar_o),
        .arready_i      (arready_i),
        .r_i            (r_i),
        .rready_o       (rready_o),
        .fetch_done_o   (fetch_done),
        .payload_o      (payload)
    );

    ip_header_csum u_csum (
        .eth_rxck       (eth_rxck),
        .rst_rx         (rst_rx),
        .csum_start_i   (csum_start),
        .conn_i         (conn_q),
        .my_ip_i        (my_ip_q),
        .ip_total_len_i (IP_TOTAL_LEN),
        .csum_o         (ip_csum),
        .csum_valid_o   (csum_valid)
    );

    frame_serializer #(.BEATS_PER_PKT(BEATS_PER_PKT)) u_ser (
        .eth_rxck       (eth_rxck),
        .rst_rx         (rst_rx),
        .frame_load_i   (frame_load),
        .conn_i         (conn_q),
        .my_mac_i       (my_mac_q),
        .my_ip_i        (my_ip_q),
        .csum_i         (ip_csum),
        .payload_i      (payload),
        .tx_o           (tx_o),
        .frame_sent_o   (frame_sent)
    );

endmodule

// ==== udp_tx_pkg.sv ====
package udp_tx_pkg;

    // field widths with a meaning
    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;
    typedef logic [7:0]  tx_byte_t;
    typedef logic [15:0] csum_t;
    typedef logic [7:0]  pkt_cnt_t;

    ////////////////////////////////////////////////////////////
    // header sizes and fixed header fields
    ////////////////////////////////////////////////////////////
    localparam int ETH_HDR_BYTES   = 14;
    localparam int IP_HDR_BYTES    = 20;
    localparam int UDP_HDR_BYTES   = 8;
    localparam int FRAME_HDR_BYTES = 42;

    localparam logic [15:0] ETH_TYPE_IPV4 = 16'h0800;
    localparam logic [7:0]  IP_VER_IHL    = 8'h45;
    localparam logic [7:0]  IP_TOS        = 8'h00;
    localparam logic [15:0] IP_IDENT      = 16'hABCD;
    // DF set, fragment offset zero
    localparam logic [15:0] IP_FLAGS_DF   = 16'h4000;
    localparam logic [7:0]  IP_TTL        = 8'd255;
    localparam logic [7:0]  IP_PROTO_UDP  = 8'd17;

    // connection settings of the far end
    typedef struct packed {
        mac_addr_t dst_mac;
        ip_addr_t  dst_ip;
        udp_port_t src_port;
        udp_port_t dst_port;
    } conn_t;

    // read address channel, len is beats minus one
    typedef struct packed {
        logic [31:0] addr;
        logic [7:0]  len;
        logic        valid;
    } axi_ar_t;

    // read data channel
    typedef struct packed {
        logic [31:0] data;
        logic        last;
        logic        valid;
    } axi_r_t;

    // byte stream toward the MAC
    typedef struct packed {
        tx_byte_t data;
        logic     valid;
        logic     last;
    } tx_stream_t;

    typedef enum logic [2:0] {
        IDLE, FETCH, CSUM, SEND, WAIT_FETCH, DONE
    } tx_state_e;

    // switch code to packets per run
    function automatic pkt_cnt_t pkt_count_f(input logic [3:0] sel);
        pkt_cnt_t cnt;
        case (sel)
            4'd0, 4'd1: cnt = 8'd1;
            4'd2:       cnt = 8'd2;
            4'd3:       cnt = 8'd4;
            4'd4:       cnt = 8'd8;
            default:    cnt = 8'd8;
        endcase
        return cnt;
    endfunction

endpackage
